// ==== project.f ====
+incdir+include
source/dc_slice_pkg.sv
source/dc_token_ring_dout.sv
source/dc_token_ring_din.sv
source/axi_single_slice.sv
source/dc_slice_master.sv
sim/tb_dc_slice_master.sv

// ==== Bender.yml ====
package:
  name: dc_slice_master

export_include_dirs:
  - include

sources:
  - files:
      - source/dc_slice_pkg.sv
      - source/dc_token_ring_dout.sv
      - source/dc_token_ring_din.sv
      - source/axi_single_slice.sv
      - source/dc_slice_master.sv
  - target: test
    files:
      - sim/tb_dc_slice_master.sv

// ==== sim/tb_dc_slice_master.sv ====
/*
 * Testbench for the dual-clock slice, master side, read path
 * Models the far domain of both rings and the AXI slave port,
 * checks AR and R ordering, back-pressure and ring full
 */

`timescale 1ns/1ps

`include "dc_slice_params.svh"

module tb_dc_slice_master;

    import dc_slice_pkg::*;

    localparam int SLOTS = `DC_BUFFER_WIDTH;
    // Wide margin over the few hundred cycles all tests take
    localparam int MAX_CYCLES = 4000;

    logic    clk_i;
    logic    rst_n_i;
    dc_ptr_t ar_writetoken_i;
    dc_ar_t  ar_data_async_i;
    dc_ptr_t ar_readpointer_o;
    dc_ptr_t r_writetoken_o;
    dc_r_t   r_data_async_o;
    dc_ptr_t r_readpointer_i;
    logic    ar_valid_o;
    dc_ar_t  ar_o;
    logic    ar_ready_i;
    logic    r_valid_i;
    dc_r_t   r_i;
    logic    r_ready_o;

    // Far AR ring and scoreboards
    dc_ar_t  ar_slots [SLOTS];
    dc_ar_t  ar_send_q [$];
    dc_ar_t  ar_expect_q [$];
    dc_r_t   r_send_q [$];
    dc_r_t   r_expect_q [$];

    logic    ar_stalled;
    dc_ar_t  ar_held;
    logic    r_taken;
    logic    r_stall;
    int      r_accepted;
    int      r_delivered;
    int      errors;
    int      tests_passed;
    int      tests_failed;
    int      cycle_count;

    dc_slice_master UUT (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .ar_writetoken_i  ( ar_writetoken_i  ),
        .ar_data_async_i  ( ar_data_async_i  ),
        .ar_readpointer_o ( ar_readpointer_o ),
        .r_writetoken_o   ( r_writetoken_o   ),
        .r_data_async_o   ( r_data_async_o   ),
        .r_readpointer_i  ( r_readpointer_i  ),
        .ar_valid_o       ( ar_valid_o       ),
        .ar_o             ( ar_o             ),
        .ar_ready_i       ( ar_ready_i       ),
        .r_valid_i        ( r_valid_i        ),
        .r_i              ( r_i              ),
        .r_ready_o        ( r_ready_o        )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic dc_ptr_t next_slot(input dc_ptr_t ptr);
        return {ptr[SLOTS-2:0], ptr[SLOTS-1]};
    endfunction

    function automatic int slot_index(input dc_ptr_t ptr);
        int idx;
        idx = 0;
        for (int i = 0; i < SLOTS; i++) begin
            if (ptr[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic dc_ar_t random_ar();
        logic [127:0] bits;
        bits = {$urandom, $urandom, $urandom, $urandom};
        return bits[$bits(dc_ar_t)-1:0];
    endfunction

    function automatic dc_r_t draw_r_beat();
        logic [127:0] bits;
        bits = {$urandom, $urandom, $urandom, $urandom};
        return bits[$bits(dc_r_t)-1:0];
    endfunction

    // Far AR slot under the DUT read pointer
    always_comb begin
        ar_data_async_i = ar_slots[0];
        for (int i = 1; i < SLOTS; i++) begin
            if (ar_readpointer_o[i]) begin
                ar_data_async_i = ar_slots[i];
            end
        end
    end

    // Far AR writer stalls when one slot is left
    always @(negedge clk_i) begin
        if (rst_n_i && ar_send_q.size() > 0
                && next_slot(ar_writetoken_i) != ar_readpointer_o) begin
            ar_slots[slot_index(ar_writetoken_i)] = ar_send_q.pop_front();
            ar_writetoken_i = next_slot(ar_writetoken_i);
        end
    end

    // AR port monitor
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (ar_stalled) begin
                assert (ar_o == ar_held) else begin
                    errors++;
                    $display("FAILED ar_o expected 0x%h got 0x%h", ar_held, ar_o);
                end
            end
            if (ar_valid_o && ar_ready_i) begin
                if (ar_expect_q.size() == 0) begin
                    errors++;
                    $display("An AR word left the DUT while none was outstanding");
                end else begin
                    assert (ar_o == ar_expect_q[0]) else begin
                        errors++;
                        $display("FAILED ar_o expected 0x%h got 0x%h", ar_expect_q[0], ar_o);
                    end
                    void'(ar_expect_q.pop_front());
                end
            end
            ar_stalled = ar_valid_o && !ar_ready_i;
            ar_held = ar_o;
        end
    end

    property ar_valid_held;
        @(posedge clk_i) disable iff (!rst_n_i)
            (ar_valid_o && !ar_ready_i) |=> ar_valid_o;
    endproperty

    assert property (ar_valid_held) else begin
        errors++;
        $display("ar_valid_o dropped before its word was taken");
    end

    // R beats accepted on the master port
    always @(posedge clk_i) begin
        if (rst_n_i && r_valid_i && r_ready_o) begin
            r_expect_q.push_back(r_i);
            r_accepted++;
            r_taken = 1'b1;
        end
    end

    // R slave driver holds valid until the transfer
    always @(negedge clk_i) begin
        if (r_taken) begin
            void'(r_send_q.pop_front());
            r_taken = 1'b0;
        end
        if (r_send_q.size() > 0) begin
            r_valid_i = 1'b1;
            r_i = r_send_q[0];
        end else begin
            r_valid_i = 1'b0;
        end
    end

    // Far R reader
    always @(negedge clk_i) begin
        if (rst_n_i && !r_stall && r_readpointer_i != r_writetoken_o) begin
            if (r_expect_q.size() == 0) begin
                errors++;
                $display("The far R reader found a beat that was never accepted");
            end else begin
                assert (r_data_async_o == r_expect_q[0]) else begin
                    errors++;
                    $display("FAILED r_data_async_o expected 0x%h got 0x%h",
                             r_expect_q[0], r_data_async_o);
                end
                void'(r_expect_q.pop_front());
            end
            r_delivered++;
            r_readpointer_i = next_slot(r_readpointer_i);
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic check_reset_values();
        int start;
        start = errors;
        assert (ar_valid_o == 1'b0) else begin
            errors++;
            $display("FAILED ar_valid_o expected 0x0 got 0x%h", ar_valid_o);
        end
        assert (r_ready_o == 1'b1) else begin
            errors++;
            $display("FAILED r_ready_o expected 0x1 got 0x%h", r_ready_o);
        end
        assert (ar_readpointer_o == dc_ptr_t'(1)) else begin
            errors++;
            $display("FAILED ar_readpointer_o expected 0x01 got 0x%h", ar_readpointer_o);
        end
        assert (r_writetoken_o == dc_ptr_t'(1)) else begin
            errors++;
            $display("FAILED r_writetoken_o expected 0x01 got 0x%h", r_writetoken_o);
        end
        finish_test("reset values", start);
    endtask

    task automatic send_ar_words(input string name, input int count, input bit random_ready);
        int start;
        dc_ar_t word;
        start = errors;
        for (int i = 0; i < count; i++) begin
            word = random_ar();
            ar_send_q.push_back(word);
            ar_expect_q.push_back(word);
        end
        while (ar_expect_q.size() != 0) begin
            @(negedge clk_i);
            ar_ready_i = random_ready ? 1'($urandom) : 1'b1;
        end
        ar_ready_i = 1'b1;
        // Catch any duplicate still in flight
        repeat (8) @(negedge clk_i);
        finish_test(name, start);
    endtask

    task automatic stream_r_beats();
        int start;
        int target;
        start = errors;
        target = r_delivered + 30;
        for (int i = 0; i < 30; i++) begin
            r_send_q.push_back(draw_r_beat());
        end
        while (r_delivered < target) begin
            @(negedge clk_i);
        end
        finish_test("R order", start);
    endtask

    task automatic stall_r_reader();
        int start;
        int first_beat;
        int target;
        start = errors;
        // Let the synchronized far pointer catch up
        repeat (4) @(negedge clk_i);
        r_stall = 1'b1;
        first_beat = r_accepted;
        target = r_delivered + 12;
        for (int i = 0; i < 12; i++) begin
            r_send_q.push_back(draw_r_beat());
        end
        while (r_ready_o) begin
            @(negedge clk_i);
        end
        assert (r_accepted - first_beat == SLOTS - 1) else begin
            errors++;
            $display("FAILED r_accepted expected 0x%h got 0x%h",
                     SLOTS - 1, r_accepted - first_beat);
        end
        repeat (6) @(negedge clk_i);
        assert (r_accepted - first_beat == SLOTS - 1) else begin
            errors++;
            $display("The R ring took beats while it was full");
        end
        r_stall = 1'b0;
        while (r_delivered < target) begin
            @(negedge clk_i);
        end
        finish_test("R full", start);
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(80);
        rst_n_i = 1'b0;
        ar_writetoken_i = dc_ptr_t'(1);
        r_readpointer_i = dc_ptr_t'(1);
        ar_ready_i = 1'b1;
        r_valid_i = 1'b0;
        r_i = '0;
        for (int i = 0; i < SLOTS; i++) begin
            ar_slots[i] = '0;
        end
        ar_stalled = 1'b0;
        ar_held = '0;
        r_taken = 1'b0;
        r_stall = 1'b0;
        r_accepted = 0;
        r_delivered = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;

        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        check_reset_values();
        send_ar_words("AR order", 20, 1'b0);
        send_ar_words("AR back-pressure", 30, 1'b1);
        stream_r_beats();
        stall_r_reader();

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== source/dc_slice_master.sv ====
/*
 * Dual-clock slice, master side, read path
 * AR words arrive from a far token ring and leave through a register
 * slice; R beats are stored in a local ring for the far domain
 */

`timescale 1ns/1ps

module dc_slice_master (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Far domain, read address
    input  dc_slice_pkg::dc_ptr_t ar_writetoken_i,
    input  dc_slice_pkg::dc_ar_t  ar_data_async_i,
    output dc_slice_pkg::dc_ptr_t ar_readpointer_o,

    // Far domain, read data
    output dc_slice_pkg::dc_ptr_t r_writetoken_o,
    output dc_slice_pkg::dc_r_t   r_data_async_o,
    input  dc_slice_pkg::dc_ptr_t r_readpointer_i,

    // AXI master, read address
    output logic                  ar_valid_o,
    output dc_slice_pkg::dc_ar_t  ar_o,
    input  logic                  ar_ready_i,

    // AXI master, read data
    input  logic                  r_valid_i,
    input  dc_slice_pkg::dc_r_t   r_i,
    output logic                  r_ready_o
);

    import dc_slice_pkg::*;

    // Ring to slice on the AR path
    logic   ar_ring_valid;
    logic   ar_ring_ready;
    dc_ar_t ar_ring_data;

    dc_token_ring_dout #(
        .T_PAYLOAD      ( dc_ar_t          )
    ) i_ar_ring (
        .clk_i          ( clk_i            ),
        .rst_n_i        ( rst_n_i          ),
        .write_token_i  ( ar_writetoken_i  ),
        .data_async_i   ( ar_data_async_i  ),
        .read_pointer_o ( ar_readpointer_o ),
        .valid_o        ( ar_ring_valid    ),
        .data_o         ( ar_ring_data     ),
        .ready_i        ( ar_ring_ready    )
    );

    // Cuts the combinational path from the far slot mux to the port
    axi_single_slice #(
        .T_PAYLOAD ( dc_ar_t       )
    ) i_ar_slice (
        .clk_i     ( clk_i         ),
        .rst_n_i   ( rst_n_i       ),
        .valid_i   ( ar_ring_valid ),
        .data_i    ( ar_ring_data  ),
        .ready_o   ( ar_ring_ready ),
        .valid_o   ( ar_valid_o    ),
        .data_o    ( ar_o          ),
        .ready_i   ( ar_ready_i    )
    );

    dc_token_ring_din #(
        .T_PAYLOAD      ( dc_r_t          )
    ) i_r_ring (
        .clk_i          ( clk_i           ),
        .rst_n_i        ( rst_n_i         ),
        .valid_i        ( r_valid_i       ),
        .data_i         ( r_i             ),
        .ready_o        ( r_ready_o       ),
        .read_pointer_i ( r_readpointer_i ),
        .write_token_o  ( r_writetoken_o  ),
        .data_async_o   ( r_data_async_o  )
    );

endmodule

// ==== source/axi_single_slice.sv ====
/*
 * Single-entry register slice
 * Registers a valid/ready stream; a held word may leave in the same
 * cycle a new one is taken
 */

`timescale 1ns/1ps

module axi_single_slice #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Upstream
    input  logic     valid_i,
    input  T_PAYLOAD data_i,
    output logic     ready_o,

    // Downstream
    output logic     valid_o,
    output T_PAYLOAD data_o,
    input  logic     ready_i
);

    logic     valid_q;
    T_PAYLOAD data_q;
    logic     load;

    // Room when empty or when the held word drains this cycle
    assign ready_o = ~valid_q | ready_i;
    assign load    = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== source/dc_token_ring_din.sv ====
/*
 * Token ring, writing side
 * Stores local beats in a ring of registers and exports the write
 * token; the far domain reads slots by its own one-hot pointer
 */

`timescale 1ns/1ps

`include "dc_slice_params.svh"

module dc_token_ring_din #(
    parameter type T_PAYLOAD = logic
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Local stream
    input  logic                  valid_i,
    input  T_PAYLOAD              data_i,
    output logic                  ready_o,

    // Far domain
    input  dc_slice_pkg::dc_ptr_t read_pointer_i,
    output dc_slice_pkg::dc_ptr_t write_token_o,
    output T_PAYLOAD              data_async_o
);

    import dc_slice_pkg::*;

    T_PAYLOAD buffer_q [`DC_BUFFER_WIDTH];

    dc_ptr_t  write_token_q;
    dc_ptr_t  read_pointer_meta_q;
    dc_ptr_t  read_pointer_sync_q;
    logic     full;
    logic     write_en;

    // Far read pointer brought into the local clock
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_pointer_meta_q <= DC_PTR_RESET;
            read_pointer_sync_q <= DC_PTR_RESET;
        end else begin
            read_pointer_meta_q <= read_pointer_i;
            read_pointer_sync_q <= read_pointer_meta_q;
        end
    end

    // One slot stays free so full and empty differ
    assign full     = (dc_ptr_rotate(write_token_q) == read_pointer_sync_q);
    assign ready_o  = ~full;
    assign write_en = valid_i & ~full;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            write_token_q <= DC_PTR_RESET;
        end else if (write_en) begin
            write_token_q <= dc_ptr_rotate(write_token_q);
        end
    end

    // Slot storage, written under the current token
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `DC_BUFFER_WIDTH; i++) begin
            if (write_en && write_token_q[i]) begin
                buffer_q[i] <= data_i;
            end
        end
    end

    assign write_token_o = write_token_q;

    // Slot picked by the raw far pointer and sampled in the far domain
    always_comb begin
        data_async_o = buffer_q[0];
        for (int i = 1; i < `DC_BUFFER_WIDTH; i++) begin
            if (read_pointer_i[i]) begin
                data_async_o = buffer_q[i];
            end
        end
    end

endmodule

// ==== source/dc_token_ring_dout.sv ====
/*
 * Token ring, reading side
 * Synchronizes the write token of a far-domain ring and presents the
 * slot under the local read pointer as a valid/ready stream
 */

`timescale 1ns/1ps

module dc_token_ring_dout #(
    parameter type T_PAYLOAD = logic
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Far domain
    input  dc_slice_pkg::dc_ptr_t write_token_i,
    input  T_PAYLOAD              data_async_i,
    output dc_slice_pkg::dc_ptr_t read_pointer_o,

    // Local stream
    output logic                  valid_o,
    output T_PAYLOAD              data_o,
    input  logic                  ready_i
);

    import dc_slice_pkg::*;

    dc_ptr_t write_token_meta_q;
    dc_ptr_t write_token_sync_q;
    dc_ptr_t read_pointer_q;
    logic    read_en;

    // Two-flop synchronizer on the far write token
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            write_token_meta_q <= DC_PTR_RESET;
            write_token_sync_q <= DC_PTR_RESET;
        end else begin
            write_token_meta_q <= write_token_i;
            write_token_sync_q <= write_token_meta_q;
        end
    end

    // Ring holds data whenever the writer is ahead of us
    assign valid_o = (write_token_sync_q != read_pointer_q);
    assign read_en = valid_o & ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_pointer_q <= DC_PTR_RESET;
        end else if (read_en) begin
            read_pointer_q <= dc_ptr_rotate(read_pointer_q);
        end
    end

    // Far side muxes its slot by our pointer
    assign read_pointer_o = read_pointer_q;
    assign data_o         = data_async_i;

endmodule

// ==== source/dc_slice_pkg.sv ====
/*
 * Crossing package
 * Payload structs for AR and R, the one-hot ring position type,
 * its reset value and the token rotation shared by both ring sides
 */

`include "dc_slice_params.svh"

package dc_slice_pkg;

    typedef struct packed {
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic [`DC_ID_WIDTH-1:0]   id;
        logic [`DC_USER_WIDTH-1:0] user;
    } dc_ar_t;

    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0] data;
        logic [1:0]                resp;
        logic                      last;
        logic [`DC_ID_WIDTH-1:0]   id;
        logic [`DC_USER_WIDTH-1:0] user;
    } dc_r_t;

    // One-hot slot position
    typedef logic [`DC_BUFFER_WIDTH-1:0] dc_ptr_t;

    localparam dc_ptr_t DC_PTR_RESET = dc_ptr_t'(1);

    // Advance to the next slot, wrapping the top bit into bit 0
    function automatic dc_ptr_t dc_ptr_rotate(input dc_ptr_t ptr);
        return {ptr[`DC_BUFFER_WIDTH-2:0], ptr[`DC_BUFFER_WIDTH-1]};
    endfunction

endpackage

// ==== include/dc_slice_params.svh ====
/*
 * Crossing parameters
 * Payload widths and token ring depth for the dual-clock read path
 */

`ifndef DC_SLICE_PARAMS_SVH
`define DC_SLICE_PARAMS_SVH

// AXI field widths
`define DC_ADDR_WIDTH 32
`define DC_DATA_WIDTH 64
`define DC_ID_WIDTH   6
`define DC_USER_WIDTH 6

// Slots per ring, also the width of every one-hot token
`define DC_BUFFER_WIDTH 8

`endif
